/* tb.f */
logic/wb_pkg.sv
logic/wb_control_store.sv
logic/writeback.sv
logic/wb_mem_sequencer.sv
logic/wb_retire_counter.sv
logic/register_file.sv
logic/wb_top.sv
sim/tb_clock.sv
sim/wb_checker.sv
sim/wb_tb.sv

/* Makefile */
# Verilator flow for the writeback stage testbench

VERILATOR ?= verilator
TOP       ?= wb_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_TEXT ?= All checks passed

SIM_BIN = $(OBJ_DIR)/V$(TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)

sim: build
	@out="$$(./$(SIM_BIN) $(SIM_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(OBJ_DIR)

/* sim/wb_tb.sv */
// Writeback stage testbench: stimulus, register model, data cache responder, summary
module wb_tb import wb_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int wait_limit = 50;

   logic                clk;
   logic                reset;
   logic                in_valid;
   logic                in_ready;
   wb_op_e              in_op;
   logic [addr_w-1:0]   in_neip;
   logic [seg_w-1:0]    in_ncs;
   logic [word_w-1:0]   in_sr1_data;
   logic [word_w-1:0]   in_alu_result;
   logic [mm_w-1:0]     in_mm_result;
   logic [word_w-1:0]   in_xchg_data;
   logic [word_w-1:0]   in_eflags;
   logic [addr_w-1:0]   in_mem_addr;
   logic [1:0]          in_size;
   logic [reg_id_w-1:0] in_drid1;
   logic [reg_id_w-1:0] in_drid2;
   logic                mem_valid;
   logic                mem_ready;
   logic [addr_w-1:0]   mem_addr;
   logic [mm_w-1:0]     mem_data;
   logic [1:0]          mem_size;
   logic [reg_id_w-1:0] dbg_gpr_id;
   logic [word_w-1:0]   dbg_gpr_data;
   logic [reg_id_w-1:0] dbg_seg_id;
   logic [seg_w-1:0]    dbg_seg_data;
   logic [reg_id_w-1:0] dbg_mm_id;
   logic [mm_w-1:0]     dbg_mm_data;
   logic [addr_w-1:0]   dbg_eip;
   logic [seg_w-1:0]    dbg_cs;
   logic [count_w-1:0]  retired_count;
   logic [count_w-1:0]  stall_count;

   // Architectural model
   logic [word_w-1:0]   gpr_m [num_gpr];
   logic [seg_w-1:0]    seg_m [num_seg];
   logic [mm_w-1:0]     mm_m [num_mm];
   logic [addr_w-1:0]   eip_m;
   logic [seg_w-1:0]    cs_m;
   int                  retired_m;
   int                  stall_m;
   logic [addr_w-1:0]   exp_addr_q [$];
   logic [mm_w-1:0]     exp_data_q [$];
   logic [1:0]          exp_size_q [$];

   int     errors;
   int     checks;
   int     tests_done;
   int     checks_mark;
   int     errors_mark;
   wb_op_e reg_ops [3] = '{op_alu, op_mov_gpr, op_call};

   tb_clock clock_inst (
      .clk (clk)
   );

   wb_top wb_top_inst (
      .clk           (clk),
      .reset         (reset),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .in_op         (in_op),
      .in_neip       (in_neip),
      .in_ncs        (in_ncs),
      .in_sr1_data   (in_sr1_data),
      .in_alu_result (in_alu_result),
      .in_mm_result  (in_mm_result),
      .in_xchg_data  (in_xchg_data),
      .in_eflags     (in_eflags),
      .in_mem_addr   (in_mem_addr),
      .in_size       (in_size),
      .in_drid1      (in_drid1),
      .in_drid2      (in_drid2),
      .mem_valid     (mem_valid),
      .mem_ready     (mem_ready),
      .mem_addr      (mem_addr),
      .mem_data      (mem_data),
      .mem_size      (mem_size),
      .dbg_gpr_id    (dbg_gpr_id),
      .dbg_gpr_data  (dbg_gpr_data),
      .dbg_seg_id    (dbg_seg_id),
      .dbg_seg_data  (dbg_seg_data),
      .dbg_mm_id     (dbg_mm_id),
      .dbg_mm_data   (dbg_mm_data),
      .dbg_eip       (dbg_eip),
      .dbg_cs        (dbg_cs),
      .retired_count (retired_count),
      .stall_count   (stall_count)
   );

   bind wb_top wb_checker checker_inst (
      .clk           (clk),
      .reset         (reset),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .in_neip       (in_neip),
      .mem_valid     (mem_valid),
      .mem_ready     (mem_ready),
      .mem_addr      (mem_addr),
      .mem_data      (mem_data),
      .mem_size      (mem_size),
      .retired_count (retired_count),
      .dbg_eip       (dbg_eip)
   );

   // ====================
   // Checking helpers
   // ====================
   task automatic expect_eq(string what, logic [63:0] got, logic [63:0] exp);
      checks++;
      assert (got === exp) else begin
         errors++;
         $display("Fail at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      end
   endtask

   task automatic abort_run(string reason);
      $display("Timeout at %0t ns: %s", $time, reason);
      $display("Checks failed");
      $finish;
   endtask

   task automatic finish_test(string name);
      tests_done++;
      $display("Test %0d %s: %0d checks, %0d errors", tests_done, name,
               checks - checks_mark, errors - errors_mark);
      checks_mark = checks;
      errors_mark = errors;
   endtask

   // Applies the writeback rules to the held payload
   function automatic void commit_model();
      eip_m = in_neip;
      retired_m++;
      case (in_op)
         op_alu:      gpr_m[in_drid1] = in_alu_result;
         op_mov_gpr:  gpr_m[in_drid1] = in_sr1_data;
         op_xchg: begin
            gpr_m[in_drid1] = in_sr1_data;
            gpr_m[in_drid2] = in_xchg_data;
         end
         op_mov_seg: begin
            if (in_drid1 < num_seg)
               seg_m[in_drid1] = in_sr1_data[seg_w-1:0];
         end
         op_ld_mm:    mm_m[in_drid1] = in_mm_result;
         op_far_jmp:  cs_m = in_ncs;
         op_call:     gpr_m[in_drid1] = in_neip;
         op_store: begin
            exp_addr_q.push_back(in_mem_addr);
            exp_data_q.push_back({in_mm_result[mm_w-1:word_w], in_sr1_data});
            exp_size_q.push_back(in_size);
         end
         op_store_mm: begin
            exp_addr_q.push_back(in_mem_addr);
            exp_data_q.push_back(in_mm_result);
            exp_size_q.push_back(size_64);
         end
         op_pushf: begin
            exp_addr_q.push_back(in_mem_addr);
            exp_data_q.push_back({in_mm_result[mm_w-1:word_w], in_eflags});
            exp_size_q.push_back(in_size);
         end
         default: ;
      endcase
   endfunction

   // ====================
   // Stimulus
   // ====================
   task automatic load_payload(wb_op_e op);
      in_op         = op;
      in_neip       = $urandom();
      in_ncs        = seg_w'($urandom());
      in_sr1_data   = $urandom();
      in_alu_result = $urandom();
      in_mm_result  = {$urandom(), $urandom()};
      in_xchg_data  = $urandom();
      in_eflags     = $urandom();
      in_mem_addr   = $urandom();
      in_size       = size_32;
      in_drid1      = reg_id_w'($urandom());
      in_drid2      = reg_id_w'($urandom());
      case (op)
         op_mov_seg:  in_drid1 = reg_id_w'($urandom_range(num_seg - 1, 0));
         op_store:    in_size = 2'($urandom_range(2, 0));
         op_store_mm: in_size = size_64;
         default: ;
      endcase
   endtask

   // Holds the payload until in_ready is seen before a rising edge
   task automatic send();
      int   waited;
      logic seen;
      waited   = 0;
      seen     = 1'b0;
      in_valid = 1'b1;
      while (!seen && waited < wait_limit) begin
         @(negedge clk);
         seen = in_ready;
         waited++;
      end
      if (!seen)
         abort_run("in_ready never rose for a pending instruction");
      commit_model();
      @(posedge clk);
      #5;
      in_valid = 1'b0;
   endtask

   task automatic issue(wb_op_e op);
      load_payload(op);
      send();
   endtask

   task automatic wait_mem_idle();
      int waited;
      waited = 0;
      while (mem_valid && waited < wait_limit) begin
         @(posedge clk);
         #5;
         waited++;
      end
      if (mem_valid)
         abort_run("store never completed on the memory port");
   endtask

   // Reads every register through the debug port, one id per cycle
   task automatic check_state();
      wait_mem_idle();
      for (int i = 0; i < num_gpr; i++) begin
         dbg_gpr_id = reg_id_w'(i);
         dbg_seg_id = reg_id_w'(i);
         dbg_mm_id  = reg_id_w'(i);
         @(negedge clk);
         expect_eq($sformatf("gpr[%0d]", i), 64'(dbg_gpr_data), 64'(gpr_m[i]));
         if (i < num_seg)
            expect_eq($sformatf("seg[%0d]", i), 64'(dbg_seg_data), 64'(seg_m[i]));
         expect_eq($sformatf("mm[%0d]", i), dbg_mm_data, mm_m[i]);
         @(posedge clk);
         #5;
      end
      expect_eq("eip", 64'(dbg_eip), 64'(eip_m));
      expect_eq("cs", 64'(dbg_cs), 64'(cs_m));
      expect_eq("retired_count", 64'(retired_count), 64'(retired_m));
      expect_eq("stall_count", 64'(stall_count), 64'(stall_m));
      expect_eq("pending stores", 64'(exp_addr_q.size()), 64'd0);
      expect_eq("in_ready", 64'(in_ready), 64'd1);
   endtask

   // ====================
   // Data cache responder
   // ====================
   task automatic check_request();
      checks++;
      assert (exp_addr_q.size() != 0) else begin
         errors++;
         $display("Unexpected store request on the memory port at %0t ns", $time);
      end
      if (exp_addr_q.size() != 0) begin
         expect_eq("mem_addr", 64'(mem_addr), 64'(exp_addr_q.pop_front()));
         expect_eq("mem_data", mem_data, exp_data_q.pop_front());
         expect_eq("mem_size", 64'(mem_size), 64'(exp_size_q.pop_front()));
      end
   endtask

   initial begin : dcache_responder
      int   delay;
      logic active;
      delay     = 0;
      active    = 1'b0;
      mem_ready = 1'b0;
      forever begin
         @(posedge clk);
         #5;
         if (reset || !mem_valid) begin
            mem_ready = 1'b0;
            active    = 1'b0;
         end else begin
            if (!active) begin
               active  = 1'b1;
               delay   = $urandom_range(3, 0);
               stall_m += delay;
               check_request();
            end
            if (delay == 0) begin
               mem_ready = 1'b1;
               active    = 1'b0;
            end else begin
               mem_ready = 1'b0;
               delay--;
            end
         end
      end
   end

   // ====================
   // Test sequence
   // ====================
   initial begin : main
      void'($urandom(33));
      errors      = 0;
      checks      = 0;
      tests_done  = 0;
      checks_mark = 0;
      errors_mark = 0;
      reset       = 1'b1;
      in_valid    = 1'b0;
      dbg_gpr_id  = '0;
      dbg_seg_id  = '0;
      dbg_mm_id   = '0;
      load_payload(op_alu);
      for (int i = 0; i < num_gpr; i++) begin
         gpr_m[i] = '0;
         mm_m[i]  = '0;
      end
      for (int i = 0; i < num_seg; i++)
         seg_m[i] = '0;
      eip_m     = '0;
      cs_m      = '0;
      retired_m = 0;
      stall_m   = 0;
      repeat (2) @(posedge clk);
      #5;
      reset = 1'b0;

      check_state();
      repeat (8) begin
         issue(reg_ops[$urandom_range(2, 0)]);
         check_state();
      end
      finish_test("register ops");

      repeat (4) begin
         issue(op_xchg);
         check_state();
      end
      repeat (2) begin
         load_payload(op_xchg);
         in_drid2 = in_drid1;
         send();
         check_state();
      end
      finish_test("exchange");

      repeat (3) begin
         issue(op_mov_seg);
         check_state();
         issue(op_ld_mm);
         check_state();
         issue(op_far_jmp);
         check_state();
      end
      finish_test("segment, MMX and far jump");

      repeat (3) begin
         issue(op_store);
         check_state();
         issue(op_store_mm);
         check_state();
         issue(op_pushf);
         check_state();
      end
      finish_test("stores with back-pressure");

      repeat (24)
         issue(wb_op_e'(4'($urandom_range(9, 0))));
      check_state();
      finish_test("back-to-back mix");

      errors += wb_top_inst.checker_inst.failures;
      $display("Summary: %0d tests, %0d checks, %0d errors", tests_done, checks, errors);
      if (errors == 0) begin
         $display("All checks passed");
      end else begin
         $display("Checks failed");
      end
      $finish;
   end

endmodule

/* sim/wb_checker.sv */
// Concurrent assertions on the writeback stage handshakes, retire counter and EIP
module wb_checker import wb_pkg::*; (
   input logic               clk,
   input logic               reset,
   input logic               in_valid,
   input logic               in_ready,
   input logic [addr_w-1:0]  in_neip,
   input logic               mem_valid,
   input logic               mem_ready,
   input logic [addr_w-1:0]  mem_addr,
   input logic [mm_w-1:0]    mem_data,
   input logic [1:0]         mem_size,
   input logic [count_w-1:0] retired_count,
   input logic [addr_w-1:0]  dbg_eip
);
   timeunit 1ns;
   timeprecision 100ps;

   int   failures;
   logic fire;

   initial failures = 0;

   assign fire = in_valid & in_ready;

   // ====================
   // Memory port
   // ====================
   reset_idle: assert property (@(posedge clk) reset |=> !mem_valid)
      else begin
         failures++;
         $error("mem_valid is high right after reset");
      end

   request_stable: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=>
         mem_valid && $stable(mem_addr) && $stable(mem_data) && $stable(mem_size))
      else begin
         failures++;
         $error("memory request changed or dropped before mem_ready");
      end

   // Input is held off while the data cache stalls
   input_stalled: assert property (@(posedge clk) disable iff (reset)
      mem_valid && !mem_ready |=> $stable(retired_count) && $stable(dbg_eip))
      else begin
         failures++;
         $error("an instruction was accepted while a store was stalled");
      end

   // ====================
   // Retire and EIP
   // ====================
   retire_step: assert property (@(posedge clk) disable iff (reset)
      fire |=> retired_count == $past(retired_count) + count_w'(1))
      else begin
         failures++;
         $error("retired_count did not step after an accepted instruction");
      end

   retire_hold: assert property (@(posedge clk) disable iff (reset)
      !fire |=> retired_count == $past(retired_count))
      else begin
         failures++;
         $error("retired_count moved without an accepted instruction");
      end

   eip_follow: assert property (@(posedge clk) disable iff (reset)
      fire |=> dbg_eip == $past(in_neip))
      else begin
         failures++;
         $error("dbg_eip does not hold the accepted next EIP");
      end

endmodule

/* sim/tb_clock.sv */
// Free-running testbench clock with a 40 ns period
module tb_clock (
   output logic clk
);
   timeunit 1ns;
   timeprecision 100ps;

   initial clk = 1'b0;

   always #20 clk = ~clk;

endmodule

/* logic/wb_top.sv */
// Writeback stage top: decoder, data select, store sequencer, counters, register file
module wb_top import wb_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   // Execute stage
   input  logic                in_valid,
   output logic                in_ready,
   input  wb_op_e              in_op,
   input  logic [addr_w-1:0]   in_neip,
   input  logic [seg_w-1:0]    in_ncs,
   input  logic [word_w-1:0]   in_sr1_data,
   input  logic [word_w-1:0]   in_alu_result,
   input  logic [mm_w-1:0]     in_mm_result,
   input  logic [word_w-1:0]   in_xchg_data,
   input  logic [word_w-1:0]   in_eflags,
   input  logic [addr_w-1:0]   in_mem_addr,
   input  logic [1:0]          in_size,
   input  logic [reg_id_w-1:0] in_drid1,
   input  logic [reg_id_w-1:0] in_drid2,
   // Data cache
   output logic                mem_valid,
   input  logic                mem_ready,
   output logic [addr_w-1:0]   mem_addr,
   output logic [mm_w-1:0]     mem_data,
   output logic [1:0]          mem_size,
   // Debug
   input  logic [reg_id_w-1:0] dbg_gpr_id,
   output logic [word_w-1:0]   dbg_gpr_data,
   input  logic [reg_id_w-1:0] dbg_seg_id,
   output logic [seg_w-1:0]    dbg_seg_data,
   input  logic [reg_id_w-1:0] dbg_mm_id,
   output logic [mm_w-1:0]     dbg_mm_data,
   output logic [addr_w-1:0]   dbg_eip,
   output logic [seg_w-1:0]    dbg_cs,
   output logic [count_w-1:0]  retired_count,
   output logic [count_w-1:0]  stall_count
);

   logic fire;
   logic busy;
   logic stalled;

   logic     ld_gpr1, ld_gpr2, ld_seg, ld_mm, ld_cseg, is_store;
   sr1_sel_e sr1_sel;

   logic                v_ld_gpr1, v_ld_gpr2, v_ld_seg, v_ld_mm, v_ld_eip, v_ld_cseg;
   logic [word_w-1:0]   gpr1_data, gpr2_data;
   logic [seg_w-1:0]    seg_data, cs_data;
   logic [mm_w-1:0]     mm_data;
   logic [addr_w-1:0]   eip_data;
   logic [reg_id_w-1:0] wr_id1, wr_id2;

   logic                store_req;
   logic [addr_w-1:0]   store_addr;
   logic [mm_w-1:0]     store_data;
   logic [1:0]          store_size;

   assign in_ready = ~busy;
   assign fire     = in_valid & in_ready;

   wb_control_store control_store_inst (
      .op       (in_op),
      .ld_gpr1  (ld_gpr1),
      .ld_gpr2  (ld_gpr2),
      .ld_seg   (ld_seg),
      .ld_mm    (ld_mm),
      .ld_cseg  (ld_cseg),
      .is_store (is_store),
      .sr1_sel  (sr1_sel)
   );

   writeback writeback_inst (
      .fire        (fire),
      .ld_gpr1     (ld_gpr1),
      .ld_gpr2     (ld_gpr2),
      .ld_seg      (ld_seg),
      .ld_mm       (ld_mm),
      .ld_cseg     (ld_cseg),
      .is_store    (is_store),
      .sr1_sel     (sr1_sel),
      .neip        (in_neip),
      .ncs         (in_ncs),
      .sr1_data    (in_sr1_data),
      .alu_result  (in_alu_result),
      .mm_result   (in_mm_result),
      .xchg_data   (in_xchg_data),
      .eflags      (in_eflags),
      .mem_addr_in (in_mem_addr),
      .size        (in_size),
      .drid1       (in_drid1),
      .drid2       (in_drid2),
      .v_ld_gpr1   (v_ld_gpr1),
      .v_ld_gpr2   (v_ld_gpr2),
      .v_ld_seg    (v_ld_seg),
      .v_ld_mm     (v_ld_mm),
      .v_ld_eip    (v_ld_eip),
      .v_ld_cseg   (v_ld_cseg),
      .gpr1_data   (gpr1_data),
      .gpr2_data   (gpr2_data),
      .seg_data    (seg_data),
      .mm_data     (mm_data),
      .cs_data     (cs_data),
      .eip_data    (eip_data),
      .wr_id1      (wr_id1),
      .wr_id2      (wr_id2),
      .store_req   (store_req),
      .store_addr  (store_addr),
      .store_data  (store_data),
      .store_size  (store_size)
   );

   wb_mem_sequencer mem_sequencer_inst (
      .clk        (clk),
      .reset      (reset),
      .store_req  (store_req),
      .store_addr (store_addr),
      .store_data (store_data),
      .store_size (store_size),
      .mem_ready  (mem_ready),
      .mem_valid  (mem_valid),
      .mem_addr   (mem_addr),
      .mem_data   (mem_data),
      .mem_size   (mem_size),
      .busy       (busy),
      .stalled    (stalled)
   );

   wb_retire_counter retire_counter_inst (
      .clk           (clk),
      .reset         (reset),
      .fire          (fire),
      .stalled       (stalled),
      .retired_count (retired_count),
      .stall_count   (stall_count)
   );

   register_file register_file_inst (
      .clk          (clk),
      .reset        (reset),
      .v_ld_gpr1    (v_ld_gpr1),
      .v_ld_gpr2    (v_ld_gpr2),
      .v_ld_seg     (v_ld_seg),
      .v_ld_mm      (v_ld_mm),
      .v_ld_eip     (v_ld_eip),
      .v_ld_cseg    (v_ld_cseg),
      .wr_id1       (wr_id1),
      .wr_id2       (wr_id2),
      .gpr1_data    (gpr1_data),
      .gpr2_data    (gpr2_data),
      .seg_data     (seg_data),
      .mm_data      (mm_data),
      .eip_data     (eip_data),
      .cs_data      (cs_data),
      .dbg_gpr_id   (dbg_gpr_id),
      .dbg_seg_id   (dbg_seg_id),
      .dbg_mm_id    (dbg_mm_id),
      .dbg_gpr_data (dbg_gpr_data),
      .dbg_seg_data (dbg_seg_data),
      .dbg_mm_data  (dbg_mm_data),
      .dbg_eip      (dbg_eip),
      .dbg_cs       (dbg_cs)
   );

endmodule

/* logic/register_file.sv */
// Architectural state: GPRs, segment, MMX, EIP and CS registers with debug reads
module register_file import wb_pkg::*; (
   input  logic                clk,
   input  logic                reset,
   input  logic                v_ld_gpr1,
   input  logic                v_ld_gpr2,
   input  logic                v_ld_seg,
   input  logic                v_ld_mm,
   input  logic                v_ld_eip,
   input  logic                v_ld_cseg,
   input  logic [reg_id_w-1:0] wr_id1,
   input  logic [reg_id_w-1:0] wr_id2,
   input  logic [word_w-1:0]   gpr1_data,
   input  logic [word_w-1:0]   gpr2_data,
   input  logic [seg_w-1:0]    seg_data,
   input  logic [mm_w-1:0]     mm_data,
   input  logic [addr_w-1:0]   eip_data,
   input  logic [seg_w-1:0]    cs_data,
   input  logic [reg_id_w-1:0] dbg_gpr_id,
   input  logic [reg_id_w-1:0] dbg_seg_id,
   input  logic [reg_id_w-1:0] dbg_mm_id,
   output logic [word_w-1:0]   dbg_gpr_data,
   output logic [seg_w-1:0]    dbg_seg_data,
   output logic [mm_w-1:0]     dbg_mm_data,
   output logic [addr_w-1:0]   dbg_eip,
   output logic [seg_w-1:0]    dbg_cs
);

   logic [word_w-1:0] gpr [num_gpr];
   logic [seg_w-1:0]  seg [num_seg];
   logic [mm_w-1:0]   mm  [num_mm];
   logic [addr_w-1:0] eip;
   logic [seg_w-1:0]  cs;

   // ====================
   // GPRs
   // ====================
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_gpr; i++)
            gpr[i] <= '0;
      end else begin
         if (v_ld_gpr1)
            gpr[wr_id1] <= gpr1_data;
         // Port 2 last, so it wins on a shared id
         if (v_ld_gpr2)
            gpr[wr_id2] <= gpr2_data;
      end
   end

   // ====================
   // Segment and MMX
   // ====================
   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_seg; i++)
            seg[i] <= '0;
      end else if (v_ld_seg && wr_id1 < num_seg) begin
         seg[wr_id1] <= seg_data;
      end
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < num_mm; i++)
            mm[i] <= '0;
      end else if (v_ld_mm) begin
         mm[wr_id1] <= mm_data;
      end
   end

   // Instruction pointer and code segment
   always_ff @(posedge clk) begin
      if (reset) begin
         eip <= '0;
         cs  <= '0;
      end else begin
         if (v_ld_eip)
            eip <= eip_data;
         if (v_ld_cseg)
            cs <= cs_data;
      end
   end

   assign dbg_gpr_data = gpr[dbg_gpr_id];
   assign dbg_seg_data = (dbg_seg_id < num_seg) ? seg[dbg_seg_id] : '0;
   assign dbg_mm_data  = mm[dbg_mm_id];
   assign dbg_eip      = eip;
   assign dbg_cs       = cs;

endmodule

/* logic/wb_retire_counter.sv */
// Saturating retire and stall-cycle counters
module wb_retire_counter import wb_pkg::*; (
   input  logic               clk,
   input  logic               reset,
   input  logic               fire,
   input  logic               stalled,
   output logic [count_w-1:0] retired_count,
   output logic [count_w-1:0] stall_count
);

   always_ff @(posedge clk) begin
      if (reset) begin
         retired_count <= '0;
      end else if (fire && retired_count != '1) begin
         retired_count <= retired_count + 1'b1;
      end
   end

   // Cycles spent waiting on the data cache
   always_ff @(posedge clk) begin
      if (reset) begin
         stall_count <= '0;
      end else if (stalled && stall_count != '1) begin
         stall_count <= stall_count + 1'b1;
      end
   end

endmodule

/* logic/wb_mem_sequencer.sv */
// Store sequencer: holds a request on the data cache port and stalls the stage
module wb_mem_sequencer import wb_pkg::*; (
   input  logic              clk,
   input  logic              reset,
   input  logic              store_req,
   input  logic [addr_w-1:0] store_addr,
   input  logic [mm_w-1:0]   store_data,
   input  logic [1:0]        store_size,
   input  logic              mem_ready,
   output logic              mem_valid,
   output logic [addr_w-1:0] mem_addr,
   output logic [mm_w-1:0]   mem_data,
   output logic [1:0]        mem_size,
   output logic              busy,
   output logic              stalled
);

   mem_state_e state;
   logic       capture;

   // A new store can only arrive when the port is free or completing
   assign capture = store_req & ((state == mem_idle) | mem_ready);

   always_ff @(posedge clk) begin
      if (reset) begin
         state <= mem_idle;
      end else begin
         case (state)
            mem_idle: begin
               if (store_req)
                  state <= mem_wait;
            end
            mem_wait: begin
               if (mem_ready && !store_req)
                  state <= mem_idle;
            end
            default: state <= mem_idle;
         endcase
      end
   end

   // Request payload
   always_ff @(posedge clk) begin
      if (capture) begin
         mem_addr <= store_addr;
         mem_data <= store_data;
         mem_size <= store_size;
      end
   end

   assign mem_valid = (state == mem_wait);
   assign stalled   = mem_valid & ~mem_ready;
   // Free again on the completing edge
   assign busy      = stalled;

endmodule

/* logic/writeback.sv */
// Writeback data select: SR1 mux, memory data, load enables gated by the accept strobe
module writeback import wb_pkg::*; (
   input  logic                fire,
   input  logic                ld_gpr1,
   input  logic                ld_gpr2,
   input  logic                ld_seg,
   input  logic                ld_mm,
   input  logic                ld_cseg,
   input  logic                is_store,
   input  sr1_sel_e            sr1_sel,
   input  logic [addr_w-1:0]   neip,
   input  logic [seg_w-1:0]    ncs,
   input  logic [word_w-1:0]   sr1_data,
   input  logic [word_w-1:0]   alu_result,
   input  logic [mm_w-1:0]     mm_result,
   input  logic [word_w-1:0]   xchg_data,
   input  logic [word_w-1:0]   eflags,
   input  logic [addr_w-1:0]   mem_addr_in,
   input  logic [1:0]          size,
   input  logic [reg_id_w-1:0] drid1,
   input  logic [reg_id_w-1:0] drid2,
   output logic                v_ld_gpr1,
   output logic                v_ld_gpr2,
   output logic                v_ld_seg,
   output logic                v_ld_mm,
   output logic                v_ld_eip,
   output logic                v_ld_cseg,
   output logic [word_w-1:0]   gpr1_data,
   output logic [word_w-1:0]   gpr2_data,
   output logic [seg_w-1:0]    seg_data,
   output logic [mm_w-1:0]     mm_data,
   output logic [seg_w-1:0]    cs_data,
   output logic [addr_w-1:0]   eip_data,
   output logic [reg_id_w-1:0] wr_id1,
   output logic [reg_id_w-1:0] wr_id2,
   output logic                store_req,
   output logic [addr_w-1:0]   store_addr,
   output logic [mm_w-1:0]     store_data,
   output logic [1:0]          store_size
);

   logic [word_w-1:0] sr1_mux;
   logic [word_w-1:0] mem_low;

   always_comb begin
      case (sr1_sel)
         sel_alu:    sr1_mux = alu_result;
         sel_sr1:    sr1_mux = sr1_data;
         sel_neip:   sr1_mux = neip;
         default:    sr1_mux = eflags;
      endcase
   end

   // Wide MMX store takes the low half of the MM result
   assign mem_low = (size == size_64) ? mm_result[word_w-1:0] : sr1_mux;

   assign gpr1_data = sr1_mux;
   assign gpr2_data = xchg_data;
   assign seg_data  = sr1_mux[seg_w-1:0];
   assign mm_data   = mm_result;
   assign cs_data   = ncs;
   assign eip_data  = neip;
   assign wr_id1    = drid1;
   assign wr_id2    = drid2;

   // ====================
   // Strobed enables
   // ====================
   assign v_ld_gpr1 = fire & ld_gpr1;
   assign v_ld_gpr2 = fire & ld_gpr2;
   assign v_ld_seg  = fire & ld_seg;
   assign v_ld_mm   = fire & ld_mm;
   assign v_ld_eip  = fire;
   assign v_ld_cseg = fire & ld_cseg;
   assign store_req = fire & is_store;

   assign store_addr = mem_addr_in;
   assign store_data = {mm_result[mm_w-1:word_w], mem_low};
   assign store_size = size;

endmodule

/* logic/wb_control_store.sv */
// Control-store decoder from writeback opcode to load enables, SR1 select and store flag
module wb_control_store import wb_pkg::*; (
   input  wb_op_e   op,
   output logic     ld_gpr1,
   output logic     ld_gpr2,
   output logic     ld_seg,
   output logic     ld_mm,
   output logic     ld_cseg,
   output logic     is_store,
   output sr1_sel_e sr1_sel
);

   always_comb begin
      ld_gpr1  = 1'b0;
      ld_gpr2  = 1'b0;
      ld_seg   = 1'b0;
      ld_mm    = 1'b0;
      ld_cseg  = 1'b0;
      is_store = 1'b0;
      sr1_sel  = sel_alu;
      case (op)
         op_alu: begin
            ld_gpr1 = 1'b1;
         end
         op_mov_gpr: begin
            ld_gpr1 = 1'b1;
            sr1_sel = sel_sr1;
         end
         op_xchg: begin
            ld_gpr1 = 1'b1;
            ld_gpr2 = 1'b1;
            sr1_sel = sel_sr1;
         end
         op_mov_seg: begin
            ld_seg  = 1'b1;
            sr1_sel = sel_sr1;
         end
         op_ld_mm: begin
            ld_mm = 1'b1;
         end
         op_far_jmp: begin
            ld_cseg = 1'b1;
         end
         // Return address goes to the destination GPR
         op_call: begin
            ld_gpr1 = 1'b1;
            sr1_sel = sel_neip;
         end
         op_store: begin
            is_store = 1'b1;
            sr1_sel  = sel_sr1;
         end
         op_store_mm: begin
            is_store = 1'b1;
         end
         op_pushf: begin
            is_store = 1'b1;
            sr1_sel  = sel_eflags;
         end
         default: begin
            ld_gpr1 = 1'b0;
         end
      endcase
   end

endmodule

/* logic/wb_pkg.sv */
// Writeback package: opcode, SR1 select and sequencer state enums, widths, counts, size codes
package wb_pkg;

   // ====================
   // Architectural widths
   // ====================
   localparam int addr_w   = 32;
   localparam int word_w   = 32;
   localparam int mm_w     = 64;
   localparam int seg_w    = 16;
   localparam int reg_id_w = 3;
   localparam int count_w  = 16;

   // Register counts
   localparam int num_gpr = 8;
   localparam int num_seg = 6;
   localparam int num_mm  = 8;

   // Data-size codes on the memory port
   localparam logic [1:0] size_8  = 2'd0;
   localparam logic [1:0] size_16 = 2'd1;
   localparam logic [1:0] size_32 = 2'd2;
   localparam logic [1:0] size_64 = 2'd3;

   // ====================
   // Encodings
   // ====================
   typedef enum logic [3:0] {
      op_alu      = 4'd0,
      op_mov_gpr  = 4'd1,
      op_xchg     = 4'd2,
      op_mov_seg  = 4'd3,
      op_ld_mm    = 4'd4,
      op_far_jmp  = 4'd5,
      op_call     = 4'd6,
      op_store    = 4'd7,
      op_store_mm = 4'd8,
      op_pushf    = 4'd9
   } wb_op_e;

   // Source of the SR1 data mux
   typedef enum logic [1:0] {
      sel_alu    = 2'd0,
      sel_sr1    = 2'd1,
      sel_neip   = 2'd2,
      sel_eflags = 2'd3
   } sr1_sel_e;

   typedef enum logic {
      mem_idle = 1'b0,
      mem_wait = 1'b1
   } mem_state_e;

endpackage
